// ==== logic/serv_lite_pkg.sv ====
package serv_lite_pkg;

   localparam int XLEN = 32;

   // the two major opcodes this core executes
   localparam logic [6:0] OPC_OP    = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM = 7'b0010011;

   // decoder state encoding
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_LOAD = 2'd1;  // operand copy cycle
   localparam logic [1:0] ST_RUN  = 2'd2;

   // funct3[1:0] of the boolean ops
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } bool_op_e;

   typedef enum logic {
      RD_ADD  = 1'b0,
      RD_BOOL = 1'b1
   } rd_sel_e;

   // one fetched word, seen as R-type or I-type
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r_view;
      struct packed {
         logic [11:0] imm12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i_view;
   } instr_u;

endpackage

// ==== logic/exec_if.sv ====
`timescale 1ns/100ps

// per-bit execution controls from the decoder
interface exec_if;

   logic                     load;       // operand copy into shift regs
   logic                     cnt_en;     // one of the 32 serial cycles
   logic                     cnt_first;  // bit 0, carry init
   logic                     cnt_last;   // bit 31
   logic [4:0]               rs1_addr;
   logic [4:0]               rs2_addr;
   logic                     imm_bit;
   logic                     op_b_imm;   // operand b from immediate
   logic                     sub;
   serv_lite_pkg::bool_op_e  bool_op;
   serv_lite_pkg::rd_sel_e   rd_sel;
   logic [4:0]               rd_addr;
   logic                     rd_wen;     // already masked for x0

   modport decoder (
      output load, cnt_en, cnt_first, cnt_last, rs1_addr, rs2_addr,
      output imm_bit, op_b_imm, sub, bool_op, rd_sel, rd_addr, rd_wen
   );

   modport alu (
      input cnt_en, cnt_first, imm_bit, op_b_imm, sub, bool_op, rd_sel
   );

   modport regfile (
      input load, cnt_en, rs1_addr, rs2_addr
   );

   modport retire (
      input cnt_en, cnt_last, rd_addr, rd_wen
   );

endinterface

// ==== logic/fetch_wb.sv ====
`timescale 1ns/100ps

module fetch_wb (
   input  logic                                clk,
   input  logic                                i_rst,
   input  logic                                i_go,
   input  logic [serv_lite_pkg::XLEN-1:0]      i_wb_rdt,
   input  logic                                i_wb_ack,
   output logic [serv_lite_pkg::XLEN-1:0]      o_wb_adr,
   output logic                                o_wb_cyc,
   output logic                                o_wb_stb,
   output serv_lite_pkg::instr_u               o_instr,
   output logic                                o_instr_valid,
   output logic [serv_lite_pkg::XLEN-1:0]      o_pc
);

   logic [serv_lite_pkg::XLEN-1:0] pc;
   logic                           cyc;
   logic                           boot;  // first fetch after reset

   assign o_wb_adr = pc;
   assign o_wb_cyc = cyc;
   assign o_wb_stb = cyc;  // classic read, stb follows cyc

   always_ff @(posedge clk) begin
      o_instr_valid <= 1'b0;
      boot          <= 1'b0;
      if (cyc && i_wb_ack) begin
         cyc           <= 1'b0;
         o_instr_valid <= 1'b1;
         pc            <= pc + 4;
      end else if (i_go || boot) begin
         cyc <= 1'b1;
      end
      if (i_rst) begin
         cyc           <= 1'b0;
         o_instr_valid <= 1'b0;
         boot          <= 1'b1;
         pc            <= '0;
      end
   end

   // captured word and its address
   always_ff @(posedge clk) begin
      if (cyc && i_wb_ack) begin
         o_instr <= i_wb_rdt;
         o_pc    <= pc;
      end
   end

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
   input  logic                   clk,
   input  logic                   i_rst,
   input  serv_lite_pkg::instr_u  i_instr,
   input  logic                   i_instr_valid,
   output logic                   o_fetch_go,
   exec_if.decoder                ex
);

   logic [1:0]                     state;
   logic [4:0]                     cnt;
   logic [3:0]                     cnt_r;   // one-hot on cnt[1:0]
   logic [serv_lite_pkg::XLEN-1:0] imm;
   logic [6:0]                     opcode;
   logic [2:0]                     funct3;
   logic                           funct7_5;
   logic [4:0]                     rd;
   logic [4:0]                     rs1;
   logic [4:0]                     rs2;
   logic                           is_op;
   logic                           is_opimm;
   logic                           f3_ok;
   logic                           supported;

   assign is_op    = (opcode == serv_lite_pkg::OPC_OP);
   assign is_opimm = (opcode == serv_lite_pkg::OPC_OPIMM);
   // add/sub, xor, or, and only
   assign f3_ok     = (funct3 == 3'b000) || (funct3[2] && (funct3[1:0] != 2'b01));
   assign supported = (is_op || is_opimm) && f3_ok;

   assign ex.load      = (state == serv_lite_pkg::ST_LOAD);
   assign ex.cnt_en    = (state == serv_lite_pkg::ST_RUN);
   assign ex.cnt_first = ex.cnt_en && (cnt[4:2] == 3'b000) && cnt_r[0];
   assign ex.cnt_last  = ex.cnt_en && (cnt[4:2] == 3'b111) && cnt_r[3];
   assign ex.rs1_addr  = rs1;
   assign ex.rs2_addr  = rs2;
   assign ex.imm_bit   = imm[0];
   assign ex.op_b_imm  = is_opimm;
   assign ex.sub       = is_op && funct7_5 && (funct3 == 3'b000);  // no SUBI
   assign ex.bool_op   = serv_lite_pkg::bool_op_e'(funct3[1:0]);
   assign ex.rd_sel    = (funct3 == 3'b000) ? serv_lite_pkg::RD_ADD : serv_lite_pkg::RD_BOOL;
   assign ex.rd_addr   = rd;
   assign ex.rd_wen    = supported && (rd != 5'd0);

   always_ff @(posedge clk) begin
      case (state)
         serv_lite_pkg::ST_IDLE: if (i_instr_valid) state <= serv_lite_pkg::ST_LOAD;
         serv_lite_pkg::ST_LOAD: state <= serv_lite_pkg::ST_RUN;
         serv_lite_pkg::ST_RUN:  if (ex.cnt_last) state <= serv_lite_pkg::ST_IDLE;
         default:                state <= serv_lite_pkg::ST_IDLE;
      endcase
      o_fetch_go <= ex.cnt_last;  // lines up with the retire pulse
      if (ex.cnt_en) begin
         cnt   <= cnt + 5'd1;
         cnt_r <= {cnt_r[2:0], cnt_r[3]};
      end
      if (i_rst) begin
         state      <= serv_lite_pkg::ST_IDLE;
         o_fetch_go <= 1'b0;
         cnt        <= 5'd0;
         cnt_r      <= 4'b0001;
      end
   end

   // fields come from both views of the same word
   always_ff @(posedge clk) begin
      if (i_instr_valid) begin
         opcode   <= i_instr.r_view.opcode;
         funct3   <= i_instr.r_view.funct3;
         funct7_5 <= i_instr.r_view.funct7[5];
         rd       <= i_instr.r_view.rd;
         rs1      <= i_instr.r_view.rs1;
         rs2      <= i_instr.r_view.rs2;
         imm      <= {{(serv_lite_pkg::XLEN-12){i_instr.i_view.imm12[11]}},
                      i_instr.i_view.imm12};
      end else if (ex.cnt_en) begin
         imm <= {imm[serv_lite_pkg::XLEN-1], imm[serv_lite_pkg::XLEN-1:1]};  // lsb first
      end
   end

endmodule

// ==== logic/serial_alu.sv ====
`timescale 1ns/100ps

module serial_alu (
   input  logic clk,
   input  logic i_rs1_bit,
   input  logic i_rs2_bit,
   output logic o_rd_bit,
   exec_if.alu  ex
);

   logic op_b;
   logic b_add;
   logic carry;
   logic c_in;
   logic sum;
   logic c_out;
   logic bool_bit;

   assign op_b  = ex.op_b_imm ? ex.imm_bit : i_rs2_bit;
   assign b_add = op_b ^ ex.sub;  // two's complement via inverted b

   // carry in is 1 on bit 0 for SUB
   assign c_in  = ex.cnt_first ? ex.sub : carry;
   assign sum   = i_rs1_bit ^ b_add ^ c_in;
   assign c_out = (i_rs1_bit & b_add) | (c_in & (i_rs1_bit ^ b_add));

   always_comb begin
      case (ex.bool_op)
         serv_lite_pkg::BOOL_XOR: bool_bit = i_rs1_bit ^ op_b;
         serv_lite_pkg::BOOL_OR:  bool_bit = i_rs1_bit | op_b;
         serv_lite_pkg::BOOL_AND: bool_bit = i_rs1_bit & op_b;
         default:                 bool_bit = 1'b0;
      endcase
   end

   assign o_rd_bit = (ex.rd_sel == serv_lite_pkg::RD_ADD) ? sum : bool_bit;

   always_ff @(posedge clk) begin
      if (ex.cnt_en) begin
         carry <= c_out;
      end
   end

endmodule

// ==== logic/serial_regfile.sv ====
`timescale 1ns/100ps

module serial_regfile (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_wr_en,
   input  logic [4:0]                      i_wr_addr,
   input  logic [serv_lite_pkg::XLEN-1:0]  i_wr_data,
   output logic                            o_rs1_bit,
   output logic                            o_rs2_bit,
   exec_if.regfile                         ex
);

   logic [serv_lite_pkg::XLEN-1:0] regs [32];
   logic [serv_lite_pkg::XLEN-1:0] rs1_word;
   logic [serv_lite_pkg::XLEN-1:0] rs2_word;
   logic [serv_lite_pkg::XLEN-1:0] rs1_sh;
   logic [serv_lite_pkg::XLEN-1:0] rs2_sh;

   // x0 is hardwired, whatever the array holds
   assign rs1_word = (ex.rs1_addr == 5'd0) ? '0 : regs[ex.rs1_addr];
   assign rs2_word = (ex.rs2_addr == 5'd0) ? '0 : regs[ex.rs2_addr];

   assign o_rs1_bit = rs1_sh[0];
   assign o_rs2_bit = rs2_sh[0];

   always_ff @(posedge clk) begin
      if (i_wr_en) begin
         regs[i_wr_addr] <= i_wr_data;  // full word after the last bit
      end
   end

   // operand shifters, lsb leaves first
   always_ff @(posedge clk) begin
      if (ex.load) begin
         rs1_sh <= rs1_word;
         rs2_sh <= rs2_word;
      end else if (ex.cnt_en) begin
         rs1_sh <= {1'b0, rs1_sh[serv_lite_pkg::XLEN-1:1]};
         rs2_sh <= {1'b0, rs2_sh[serv_lite_pkg::XLEN-1:1]};
      end
      if (i_rst) begin
         rs1_sh <= '0;
         rs2_sh <= '0;
      end
   end

endmodule

// ==== logic/retire_port.sv ====
`timescale 1ns/100ps

module retire_port (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_rd_bit,
   input  logic [serv_lite_pkg::XLEN-1:0]  i_pc,
   output logic                            o_wr_en,
   output logic [4:0]                      o_wr_addr,
   output logic [serv_lite_pkg::XLEN-1:0]  o_wr_data,
   output logic                            o_ret_valid,
   output logic                            o_ret_wen,
   output logic [4:0]                      o_ret_rd,
   output logic [serv_lite_pkg::XLEN-1:0]  o_ret_data,
   output logic [serv_lite_pkg::XLEN-1:0]  o_ret_pc,
   output logic                            o_fetch_go,
   exec_if.retire                          ex
);

   logic [serv_lite_pkg::XLEN-1:0] res_next;

   // the word as it will stand once the current bit is in
   assign res_next = {i_rd_bit, o_ret_data[serv_lite_pkg::XLEN-1:1]};

   assign o_wr_en   = ex.cnt_last && ex.rd_wen;  // same edge as retire
   assign o_wr_addr = ex.rd_addr;
   assign o_wr_data = res_next;

   assign o_ret_rd   = ex.rd_addr;
   assign o_ret_pc   = i_pc;
   assign o_fetch_go = o_ret_valid;

   always_ff @(posedge clk) begin
      o_ret_valid <= ex.cnt_last;
      o_ret_wen   <= ex.cnt_last && ex.rd_wen;
      if (i_rst) begin
         o_ret_valid <= 1'b0;
         o_ret_wen   <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ex.cnt_en) o_ret_data <= res_next;
   end

endmodule

// ==== logic/serv_lite_top.sv ====
`timescale 1ns/100ps

module serv_lite_top (
   input  logic                            clk,
   input  logic                            i_rst,
   output logic [serv_lite_pkg::XLEN-1:0]  o_wb_adr,
   output logic                            o_wb_cyc,
   output logic                            o_wb_stb,
   input  logic [serv_lite_pkg::XLEN-1:0]  i_wb_rdt,
   input  logic                            i_wb_ack,
   output logic                            o_ret_valid,
   output logic                            o_ret_wen,
   output logic [4:0]                      o_ret_rd,
   output logic [serv_lite_pkg::XLEN-1:0]  o_ret_data,
   output logic [serv_lite_pkg::XLEN-1:0]  o_ret_pc
);

   serv_lite_pkg::instr_u          instr;
   logic                           instr_valid;
   logic [serv_lite_pkg::XLEN-1:0] pc;
   logic                           fetch_go;
   logic                           rs1_bit;
   logic                           rs2_bit;
   logic                           rd_bit;
   logic                           wr_en;
   logic [4:0]                     wr_addr;
   logic [serv_lite_pkg::XLEN-1:0] wr_data;

   exec_if u_exec ();

   fetch_wb u_fetch (
      .clk(clk), .i_rst(i_rst), .i_go(fetch_go),
      .i_wb_rdt(i_wb_rdt), .i_wb_ack(i_wb_ack),
      .o_wb_adr(o_wb_adr), .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb),
      .o_instr(instr), .o_instr_valid(instr_valid), .o_pc(pc)
   );

   instr_decode u_decode (
      .clk(clk), .i_rst(i_rst), .i_instr(instr), .i_instr_valid(instr_valid),
      .o_fetch_go(fetch_go), .ex(u_exec.decoder)
   );

   serial_alu u_alu (
      .clk(clk), .i_rs1_bit(rs1_bit), .i_rs2_bit(rs2_bit), .o_rd_bit(rd_bit),
      .ex(u_exec.alu)
   );

   serial_regfile u_regfile (
      .clk(clk), .i_rst(i_rst), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
      .i_wr_data(wr_data), .o_rs1_bit(rs1_bit), .o_rs2_bit(rs2_bit),
      .ex(u_exec.regfile)
   );

   // next fetch is started by the decoder, in step with the retire
   retire_port u_retire (
      .clk(clk), .i_rst(i_rst), .i_rd_bit(rd_bit), .i_pc(pc),
      .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
      .o_ret_valid(o_ret_valid), .o_ret_wen(o_ret_wen), .o_ret_rd(o_ret_rd),
      .o_ret_data(o_ret_data), .o_ret_pc(o_ret_pc), .o_fetch_go(),
      .ex(u_exec.retire)
   );

endmodule

// ==== bench/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int PROG_LEN = 200;
localparam int INIT_LEN = 31;  // x1..x31 get a value first

logic [31:0] prog [PROG_LEN];
logic [31:0] model_regs [32];
logic [31:0] model_pc;
integer      seed;

// mostly R and I ops, a few unsupported words
task automatic build_program();
   logic [31:0] w;
   logic [2:0]  f3;
   logic [6:0]  f7;
   logic [4:0]  rd;
   int          pick;
   int          i;
   for (i = 0; i < PROG_LEN; i++) begin
      w    = $random(seed);
      pick = {$random(seed)} % 16;
      case ({$random(seed)} % 4)
         0:       f3 = 3'b000;
         1:       f3 = 3'b100;
         2:       f3 = 3'b110;
         default: f3 = 3'b111;
      endcase
      f7 = (f3 == 3'b000 && w[0]) ? 7'b0100000 : 7'b0000000;  // SUB half the time
      rd = (pick == 15) ? 5'd0 : w[11:7];
      if (pick == 14) w[19:15] = 5'd0;  // x0 as a source
      if (i < INIT_LEN) begin
         rd = 5'(i + 1);
         w  = {w[31:20], 5'd0, 3'b000, rd, serv_lite_pkg::OPC_OPIMM};
      end else if (pick < 2) begin
         if (w[6:0] == serv_lite_pkg::OPC_OP || w[6:0] == serv_lite_pkg::OPC_OPIMM)
            w[14:12] = 3'b001;  // shift group, not executed here
      end else if (pick < 9) begin
         w = {f7, w[24:20], w[19:15], f3, rd, serv_lite_pkg::OPC_OP};
      end else begin
         w = {w[31:20], w[19:15], f3, rd, serv_lite_pkg::OPC_OPIMM};
      end
      prog[i] = w;
   end
endtask

// expected retire of one word against the model registers
task automatic predict_retire(input logic [31:0] w, output logic ok, output logic wen,
                              output logic [31:0] res);
   logic [31:0] a;
   logic [31:0] b;
   logic        is_op;
   is_op = (w[6:0] == serv_lite_pkg::OPC_OP);
   a     = model_regs[w[19:15]];
   b     = is_op ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
   ok    = (is_op || w[6:0] == serv_lite_pkg::OPC_OPIMM) &&
           (w[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111});
   case (w[14:12])
      3'b000:  res = (is_op && w[30]) ? a - b : a + b;
      3'b100:  res = a ^ b;
      3'b110:  res = a | b;
      3'b111:  res = a & b;
      default: res = '0;
   endcase
   wen = ok && (w[11:7] != 5'd0);
endtask

// past the program end, opcode field zero
function automatic logic [31:0] fill_word(input logic [31:0] adr);
   return {adr[31:7] ^ adr[24:0], 7'h00};
endfunction

`endif

// ==== bench/core_tb.sv ====
`timescale 1ns/100ps

module core_tb;

   localparam int CLK_PERIOD   = 8;
   localparam int RETIRE_LIMIT = 60;  // worst case is about 41 cycles

   logic        clk;
   logic        i_rst;
   logic [31:0] o_wb_adr;
   logic        o_wb_cyc;
   logic        o_wb_stb;
   logic [31:0] i_wb_rdt;
   logic        i_wb_ack;
   logic        o_ret_valid;
   logic        o_ret_wen;
   logic [4:0]  o_ret_rd;
   logic [31:0] o_ret_data;
   logic [31:0] o_ret_pc;
   int          n_checks;
   int          n_errors;
   int          n_tests;
   int          wait_left;  // wait states before the next ack
   int          fetch_idx;

   `include "core_model.svh"

   localparam int WATCHDOG_NS = PROG_LEN * (35 + 4 + 2) * CLK_PERIOD + 100 * CLK_PERIOD;

   serv_lite_top u_serv_lite_top (
      .clk(clk), .i_rst(i_rst),
      .o_wb_adr(o_wb_adr), .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb),
      .i_wb_rdt(i_wb_rdt), .i_wb_ack(i_wb_ack),
      .o_ret_valid(o_ret_valid), .o_ret_wen(o_ret_wen), .o_ret_rd(o_ret_rd),
      .o_ret_data(o_ret_data), .o_ret_pc(o_ret_pc)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Fail at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // instruction memory with 0 to 3 wait cycles per read
   always @(posedge clk) begin
      i_wb_ack <= 1'b0;
      if (o_wb_cyc && o_wb_stb && !i_wb_ack) begin
         if (wait_left == 0) begin
            fetch_idx = int'(o_wb_adr >> 2);
            compare(o_wb_adr, model_pc, "fetch address");
            i_wb_ack  <= 1'b1;
            i_wb_rdt  <= (fetch_idx < PROG_LEN) ? prog[fetch_idx] : fill_word(o_wb_adr);
            wait_left <= {$random(seed)} % 4;
         end else begin
            wait_left <= wait_left - 1;
         end
      end
   end

   // waits for each retire in turn and checks it against the model
   task automatic run_range(input int first, input int last, input string name);
      int          errs_at_start;
      int          cycles;
      int          k;
      logic        ok;
      logic        wen;
      logic [31:0] res;
      logic [31:0] w;
      errs_at_start = n_errors;
      for (k = first; k < last; k++) begin
         cycles = 0;
         do begin
            @(posedge clk);
            cycles++;
         end while (!o_ret_valid && cycles < RETIRE_LIMIT);
         if (!o_ret_valid) begin
            n_errors++;
            $display("no retire seen within %0d cycles for instruction %0d", RETIRE_LIMIT, k);
            break;
         end
         w = prog[k];
         predict_retire(w, ok, wen, res);
         compare(o_ret_pc, model_pc, "retire pc");
         compare({27'd0, o_ret_rd}, {27'd0, w[11:7]}, "retire rd");
         compare({31'd0, o_ret_wen}, {31'd0, wen}, "retire wen");
         if (ok) compare(o_ret_data, res, "retire data");
         if (wen) model_regs[w[11:7]] = res;
         model_pc = model_pc + 32'd4;
      end
      n_tests++;
      $display("test %s: %0d instructions, %0d errors", name, last - first,
               n_errors - errs_at_start);
   endtask

   initial begin
      int cycles;
      clk       = 1'b0;
      seed      = 38083;
      n_checks  = 0;
      n_errors  = 0;
      n_tests   = 0;
      wait_left = 0;
      model_pc  = '0;
      foreach (model_regs[r]) model_regs[r] = '0;
      build_program();
      i_rst    <= 1'b1;
      i_wb_ack <= 1'b0;
      i_wb_rdt <= '0;
      repeat (2) @(posedge clk);
      i_rst <= 1'b0;

      compare({31'd0, o_ret_valid}, 32'd0, "ret_valid after reset");
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!o_wb_cyc && cycles < RETIRE_LIMIT);
      if (!o_wb_cyc) begin
         n_errors++;
         $display("no bus cycle started after reset was released");
      end
      compare(o_wb_adr, 32'd0, "first fetch address");
      n_tests++;
      $display("test reset_and_first_fetch: %0d errors", n_errors);

      run_range(0, INIT_LEN, "register_init");
      run_range(INIT_LEN, PROG_LEN, "random_program");

      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run took longer than %0d ns and the core stopped retiring",
               WATCHDOG_NS);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+bench
logic/serv_lite_pkg.sv
logic/exec_if.sv
logic/fetch_wb.sv
logic/instr_decode.sv
logic/serial_alu.sv
logic/serial_regfile.sv
logic/retire_port.sv
logic/serv_lite_top.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then decide from the simulation log
rm -rf obj_dir &&
verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module core_tb \
   -o core_sim > build.log 2>&1 &&
./obj_dir/core_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
